// File: bench/vsld_asserts.sv
////////////////////
// Protocol checks on the slide subsystem top
// Bound into vsld_top, flags handshake and port conflicts
////////////////////
`timescale 1ns/1ps

module vsld_asserts (
  input logic clk_i,
  input logic rst_i,
  input logic cmd_req_i,
  input logic cmd_ack_i,
  input logic rsp_req_i,
  input logic rsp_ack_i,
  input logic host_we_i,
  input logic vrf_we_i
);

  int unsigned fail_cnt = 0;

  // Ack answers a request that was pending at the capture edge
  ack_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cmd_ack_i) |-> $past(cmd_req_i))
  else begin
    $error("cmd ack rose without a pending request");
    fail_cnt++;
  end

  // Response stays up until the host acknowledges it
  rsp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_req_i && !rsp_ack_i) |=> rsp_req_i)
  else begin
    $error("rsp req dropped before rsp ack");
    fail_cnt++;
  end

  // Host port and slider never write in the same cycle
  no_write_clash: assert property (@(posedge clk_i) disable iff (rst_i)
    !(vrf_we_i && host_we_i))
  else begin
    $error("slider write during a host write");
    fail_cnt++;
  end

endmodule

bind vsld_top vsld_asserts i_asserts (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .cmd_req_i (cmd_req_i),
  .cmd_ack_i (cmd_ack_o),
  .rsp_req_i (rsp_req_o),
  .rsp_ack_i (rsp_ack_i),
  .host_we_i (host_we_i),
  .vrf_we_i  (vrf_we)
);

// File: bench/vsld_tb.sv
////////////////////
// Directed testbench of the vector slide subsystem
// Loads vs2 and vd, issues one slide, checks vd against a model
////////////////////
`timescale 1ns/1ps
`include "vsld_settings.svh"

module vsld_tb import vsld_pkg::*; ();

  localparam int WB       = `VSLD_WORD_BYTES;
  localparam int WORDS    = `VSLD_WORDS_PER_VREG;
  localparam int VLMAX_B  = WB * WORDS;
  localparam int NR_WORDS = `VSLD_NR_VREGS * WORDS;
  // About 30 tests of up to 60 cycles each plus margin
  localparam int CYCLE_LIMIT = 30 * 60 + 200;
  localparam int WAIT_LIMIT  = 6 + WORDS + 20;

  typedef logic [WORDS-1:0][8*WB-1:0] vreg_t;

  logic        clk = 1'b0;
  logic        rst;
  sld_cmd_t    cmd;
  logic        cmd_req;
  logic        cmd_ack;
  sld_rsp_t    rsp;
  logic        rsp_req;
  logic        rsp_ack;
  vreg_addr_t  host_addr;
  vreg_data_t  host_wdata;
  logic        host_we;
  vreg_data_t  host_rdata;

  vreg_data_t  model_mem [NR_WORDS];
  int unsigned cycles = 0;
  int          n_tests = 0;
  int          n_fail = 0;
  int          errors = 0;

  vsld_top UUT (
    .clk_i        (clk),
    .rst_i        (rst),
    .cmd_i        (cmd),
    .cmd_req_i    (cmd_req),
    .cmd_ack_o    (cmd_ack),
    .rsp_o        (rsp),
    .rsp_req_o    (rsp_req),
    .rsp_ack_i    (rsp_ack),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_we_i    (host_we),
    .host_rdata_o (host_rdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input vreg_data_t got, input vreg_data_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_rsp(input sld_rsp_t got, input sld_rsp_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: response id %0d, expected %0d", $time, got.id, exp.id);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  function automatic vreg_addr_t word_addr(input vreg_num_t r, input int w);
    return vreg_addr_t'(int'(r) * WORDS + w);
  endfunction

  task automatic write_word(input vreg_addr_t a, input vreg_data_t d);
    @(negedge clk);
    host_we = 1'b1;
    host_addr = a;
    host_wdata = d;
    @(negedge clk);
    host_we = 1'b0;
    model_mem[a] = d;
  endtask

  task automatic load_random(input vreg_num_t r);
    for (int w = 0; w < WORDS; w++) begin
      write_word(word_addr(r, w), $urandom);
    end
  endtask

  task automatic read_vreg(input vreg_num_t r, output vreg_t v);
    for (int w = 0; w < WORDS; w++) begin
      @(negedge clk);
      host_addr = word_addr(r, w);
      @(negedge clk);
      v[w] = host_rdata;
    end
  endtask

  task automatic check_vreg(input vreg_num_t r);
    vreg_t got;
    read_vreg(r, got);
    for (int w = 0; w < WORDS; w++) begin
      check_word(got[w], model_mem[word_addr(r, w)], $sformatf("v%0d word %0d", r, w));
    end
  endtask

  // Four-phase command handshake
  task automatic run_cmd(input sld_cmd_t c);
    int n;
    @(negedge clk);
    cmd = c;
    cmd_req = 1'b1;
    n = 0;
    while (!cmd_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ack) begin
      $display("Command %0d was never acknowledged", c.id);
      errors++;
    end
    cmd_req = 1'b0;
    n = 0;
    while (cmd_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
  endtask

  // Response handshake with the ack held back for hold cycles
  task automatic wait_rsp(input sld_id_t id, input int hold);
    sld_rsp_t exp;
    int       n;
    exp.id = id;
    n = 0;
    while (!rsp_req && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!rsp_req) begin
      $display("No response arrived for command %0d", id);
      errors++;
      return;
    end
    check_rsp(rsp, exp);
    repeat (hold) begin
      @(negedge clk);
      check_bit(rsp_req, 1'b1, "rsp_req while ack is held low");
    end
    rsp_ack = 1'b1;
    n = 0;
    while (rsp_req && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    rsp_ack = 1'b0;
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  task automatic apply_model(input sld_cmd_t c);
    logic [7:0] src [VLMAX_B];
    logic [7:0] dst [VLMAX_B];
    int         ew;
    int         n_el;
    int         j;
    longint     amt;
    logic       keep;
    logic       zero;
    logic       use_rs1;
    ew = 1 << c.vsew;
    n_el = VLMAX_B / ew;
    amt = longint'(c.rs1);
    for (int b = 0; b < VLMAX_B; b++) begin
      src[b] = model_mem[word_addr(c.vs2, b / WB)][8*(b%WB) +: 8];
      dst[b] = model_mem[word_addr(c.vd, b / WB)][8*(b%WB) +: 8];
    end
    // Element by element and only below vl
    for (int i = 0; i < int'(c.vl); i++) begin
      keep = 1'b0;
      zero = 1'b0;
      use_rs1 = 1'b0;
      j = 0;
      case (c.op)
        VSLIDEUP: begin
          keep = (i < amt);
          if (!keep) j = i - int'(amt);
        end
        VSLIDEDOWN: begin
          zero = (i + amt >= n_el);
          if (!zero) j = i + int'(amt);
        end
        VSLIDE1UP: begin
          use_rs1 = (i == 0);
          j = i - 1;
        end
        default: begin
          use_rs1 = (i == int'(c.vl) - 1);
          j = i + 1;
        end
      endcase
      for (int b = 0; b < ew; b++) begin
        if (use_rs1) dst[i*ew+b] = c.rs1[8*b +: 8];
        else if (zero) dst[i*ew+b] = 8'h00;
        else if (!keep) dst[i*ew+b] = src[j*ew+b];
      end
    end
    for (int b = 0; b < VLMAX_B; b++) begin
      model_mem[word_addr(c.vd, b / WB)][8*(b%WB) +: 8] = dst[b];
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  function automatic sld_cmd_t make_cmd(input int id, input sld_op_e op, input vsew_e ew,
                                        input int vs2, input int vd, input int vl,
                                        input logic [31:0] rs1);
    sld_cmd_t c;
    c.id = sld_id_t'(id);
    c.op = op;
    c.vsew = ew;
    c.vs2 = vreg_num_t'(vs2);
    c.vd = vreg_num_t'(vd);
    c.vl = 5'(vl);
    c.rs1 = rs1;
    return c;
  endfunction

  task automatic finish_test(input string name, input int err_before);
    n_tests++;
    if (errors == err_before) begin
      $display("PASS  %s", name);
    end else begin
      n_fail++;
      $display("FAIL  %s", name);
    end
  endtask

  task automatic do_slide(input sld_op_e op, input vsew_e ew, input int vl,
                          input logic [31:0] rs1);
    sld_cmd_t c;
    int       err_before;
    err_before = errors;
    c = make_cmd(n_tests, op, ew, n_tests % 8, (n_tests + 3) % 8, vl, rs1);
    load_random(c.vs2);
    load_random(c.vd);
    apply_model(c);
    run_cmd(c);
    wait_rsp(c.id, 0);
    check_vreg(c.vd);
    finish_test($sformatf("%s sew=%0d vl=%0d rs1=%0d", op.name(), 8 << ew, vl, rs1),
                err_before);
  endtask

  task automatic test_reset();
    int err_before;
    err_before = errors;
    check_bit(cmd_ack, 1'b0, "cmd_ack after reset");
    check_bit(rsp_req, 1'b0, "rsp_req after reset");
    for (int r = 0; r < `VSLD_NR_VREGS; r++) begin
      check_vreg(vreg_num_t'(r));
    end
    finish_test("reset state", err_before);
  endtask

  task automatic test_slideup();
    int vl;
    for (int e = 0; e < 3; e++) begin
      // One element short of VLMAX so the top element must survive
      vl = VLMAX_B / (1 << e) - 1;
      do_slide(VSLIDEUP, vsew_e'(e), vl, 0);
      do_slide(VSLIDEUP, vsew_e'(e), vl, 1);
      do_slide(VSLIDEUP, vsew_e'(e), vl, 3);
      do_slide(VSLIDEUP, vsew_e'(e), vl, vl + 1);
    end
  endtask

  task automatic test_slidedown();
    int vl;
    for (int e = 0; e < 3; e++) begin
      vl = VLMAX_B / (1 << e) - 1;
      do_slide(VSLIDEDOWN, vsew_e'(e), vl, 1);
      do_slide(VSLIDEDOWN, vsew_e'(e), vl, 3);
      // Whole source lies past VLMAX
      do_slide(VSLIDEDOWN, vsew_e'(e), vl + 1, 40);
    end
  endtask

  task automatic test_slide1();
    for (int e = 0; e < 3; e++) begin
      do_slide(VSLIDE1UP, vsew_e'(e), VLMAX_B / (1 << e), $urandom);
      do_slide(VSLIDE1DOWN, vsew_e'(e), VLMAX_B / (1 << e), $urandom);
    end
  endtask

  // Second command waits while the first response is held
  task automatic test_backpressure();
    sld_cmd_t c1;
    sld_cmd_t c2;
    int       err_before;
    err_before = errors;
    c1 = make_cmd(n_tests, VSLIDEDOWN, EW_16, 0, 1, 8, 2);
    c2 = make_cmd(n_tests + 1, VSLIDEUP, EW_8, 1, 2, 16, 5);
    load_random(c1.vs2);
    load_random(c1.vd);
    load_random(c2.vd);
    apply_model(c1);
    apply_model(c2);
    run_cmd(c1);
    @(negedge clk);
    cmd = c2;
    cmd_req = 1'b1;
    wait_rsp(c1.id, 5);
    check_bit(cmd_ack, 1'b0, "cmd_ack before the response handshake ended");
    run_cmd(c2);
    wait_rsp(c2.id, 0);
    check_vreg(c1.vd);
    check_vreg(c2.vd);
    finish_test("held response and chained command", err_before);
  endtask

  initial begin
    void'($urandom(32'h905775ee));
    for (int w = 0; w < NR_WORDS; w++) begin
      model_mem[w] = '0;
    end
    rst = 1'b1;
    cmd = '0;
    cmd_req = 1'b0;
    rsp_ack = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    host_we = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_slideup();
    test_slidedown();
    test_slide1();
    test_backpressure();

    errors = errors + int'(UUT.i_asserts.fail_cnt);
    $display("Tests %0d, failed %0d, errors %0d", n_tests, n_fail, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: common/vsld_pkg.sv
////////////////////
// Shared types of the vector slide subsystem
// Modules pull these in with a wildcard import in their header
////////////////////
`include "vsld_settings.svh"

package vsld_pkg;

  // Slide opcodes
  typedef enum logic [1:0] {
    VSLIDEUP    = 2'd0,
    VSLIDEDOWN  = 2'd1,
    VSLIDE1UP   = 2'd2,
    VSLIDE1DOWN = 2'd3
  } sld_op_e;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef logic [$clog2(`VSLD_NR_VREGS)-1:0]                      vreg_num_t;
  typedef logic [$clog2(`VSLD_NR_VREGS*`VSLD_WORDS_PER_VREG)-1:0] vreg_addr_t;
  typedef logic [8*`VSLD_WORD_BYTES-1:0]                          vreg_data_t;
  typedef logic [`VSLD_WORD_BYTES-1:0]                            vreg_be_t;
  typedef logic [5:0]                                             vlen_t;
  typedef logic [`VSLD_ID_W-1:0]                                  sld_id_t;

  // Instruction as issued by the host
  typedef struct packed {
    sld_id_t     id;
    sld_op_e     op;
    vsew_e       vsew;
    vreg_num_t   vd;
    vreg_num_t   vs2;
    logic [4:0]  vl;
    logic [31:0] rs1;
  } sld_cmd_t;

  // Instruction with lengths already converted to bytes
  typedef struct packed {
    sld_cmd_t cmd;
    vlen_t    vl_bytes;
    vlen_t    amount_bytes;
  } sld_req_t;

  typedef struct packed {
    sld_id_t id;
  } sld_rsp_t;

  // One byte-enabled word write into the register file
  typedef struct packed {
    vreg_addr_t waddr;
    vreg_data_t wdata;
    vreg_be_t   wbe;
  } vrf_wreq_t;

endpackage

// File: common/vsld_settings.svh
////////////////////
// Geometry of the vector slide subsystem
// Include this header wherever word or register sizes are needed
////////////////////
`ifndef VSLD_SETTINGS_SVH
`define VSLD_SETTINGS_SVH

// Bytes in one register file word
`define VSLD_WORD_BYTES 4

// Number of vector registers
`define VSLD_NR_VREGS 8

// Words per vector register, so VLMAX is 16 bytes
`define VSLD_WORDS_PER_VREG 4

// Width of the instruction id
`define VSLD_ID_W 3

`endif

// File: design/vsld_req_queue.sv
////////////////////
// Command intake of the slide unit
// Takes one instruction over a four-phase req/ack port and holds it
////////////////////
`timescale 1ns/1ps
`include "vsld_settings.svh"

module vsld_req_queue import vsld_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  sld_cmd_t cmd_i,
  input  logic     cmd_req_i,
  output logic     cmd_ack_o,
  output sld_req_t req_o,
  output logic     req_valid_o,
  input  logic     req_ready_i
);

  localparam int VLMAX_B = `VSLD_WORD_BYTES * `VSLD_WORDS_PER_VREG;

  typedef enum logic {
    IDLE,
    ACKED
  } q_state_e;

  q_state_e   state_q;
  logic       full_q;
  logic       capture;
  sld_req_t   req_d;
  sld_req_t   req_q;
  logic [7:0] vl_wide;
  logic [7:0] amt_wide;

  // Only one instruction in flight, so wait for an idle slider as well
  assign capture = (state_q == IDLE) && cmd_req_i && !full_q && req_ready_i;

  // Element counts to byte counts, saturated at VLMAX
  always_comb begin
    vl_wide   = {3'b000, cmd_i.vl} << cmd_i.vsew;
    amt_wide  = {3'b000, cmd_i.rs1[4:0]} << cmd_i.vsew;
    req_d.cmd = cmd_i;
    req_d.vl_bytes = (vl_wide > VLMAX_B) ? vlen_t'(VLMAX_B) : vl_wide[5:0];
    if (cmd_i.op == VSLIDE1UP || cmd_i.op == VSLIDE1DOWN) begin
      // Slide by one element and spread the scalar over the word
      req_d.amount_bytes = vlen_t'(1) << cmd_i.vsew;
      case (cmd_i.vsew)
        EW_8:    req_d.cmd.rs1 = {4{cmd_i.rs1[7:0]}};
        EW_16:   req_d.cmd.rs1 = {2{cmd_i.rs1[15:0]}};
        default: req_d.cmd.rs1 = cmd_i.rs1;
      endcase
    end else if ((|cmd_i.rs1[31:5]) || (amt_wide > VLMAX_B)) begin
      req_d.amount_bytes = vlen_t'(VLMAX_B);
    end else begin
      req_d.amount_bytes = amt_wide[5:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      full_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (capture) begin
            state_q <= ACKED;
          end
        end
        ACKED: begin
          // Drop ack once the host has dropped req
          if (!cmd_req_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (capture) begin
        full_q <= 1'b1;
      end else if (req_valid_o && req_ready_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= req_d;
    end
  end

  assign cmd_ack_o   = (state_q == ACKED);
  assign req_o       = req_q;
  assign req_valid_o = full_q;

endmodule

// File: design/vsld_top.sv
////////////////////
// Top of the vector slide subsystem
// Chains the command queue, the slider and the register file
////////////////////
`timescale 1ns/1ps

module vsld_top import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  sld_cmd_t   cmd_i,
  input  logic       cmd_req_i,
  output logic       cmd_ack_o,
  output sld_rsp_t   rsp_o,
  output logic       rsp_req_o,
  input  logic       rsp_ack_i,
  input  vreg_addr_t host_addr_i,
  input  vreg_data_t host_wdata_i,
  input  logic       host_we_i,
  output vreg_data_t host_rdata_o
);

  // Queue to slider
  sld_req_t   req;
  logic       req_valid;
  logic       req_ready;

  // Slider to register file
  vreg_addr_t vrf_raddr;
  vreg_data_t vrf_rdata;
  vrf_wreq_t  vrf_wreq;
  logic       vrf_we;

  vsld_req_queue i_req_queue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .cmd_req_i   (cmd_req_i),
    .cmd_ack_o   (cmd_ack_o),
    .req_o       (req),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready)
  );

  vsld_slider i_slider (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .vrf_raddr_o (vrf_raddr),
    .vrf_rdata_i (vrf_rdata),
    .vrf_wreq_o  (vrf_wreq),
    .vrf_we_o    (vrf_we),
    .rsp_o       (rsp_o),
    .rsp_req_o   (rsp_req_o),
    .rsp_ack_i   (rsp_ack_i)
  );

  vsld_vrf i_vrf (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .raddr_i      (vrf_raddr),
    .rdata_o      (vrf_rdata),
    .wreq_i       (vrf_wreq),
    .we_i         (vrf_we),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_we_i    (host_we_i),
    .host_rdata_o (host_rdata_o)
  );

endmodule

// File: src.f
+incdir+common
common/vsld_pkg.sv
design/vsld_req_queue.sv
vsldu/vsld_slider.sv
vsldu/vsld_vrf.sv
design/vsld_top.sv
bench/vsld_asserts.sv
bench/vsld_tb.sv

// File: vsldu/vsld_slider.sv
////////////////////
// Slide engine, walks vd one word per cycle
// Reads vs2, shifts bytes across words and writes vd with byte enables
////////////////////
`timescale 1ns/1ps
`include "vsld_settings.svh"

module vsld_slider import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  sld_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output vreg_addr_t vrf_raddr_o,
  input  vreg_data_t vrf_rdata_i,
  output vrf_wreq_t  vrf_wreq_o,
  output logic       vrf_we_o,
  output sld_rsp_t   rsp_o,
  output logic       rsp_req_o,
  input  logic       rsp_ack_i
);

  localparam int WB     = `VSLD_WORD_BYTES;
  localparam int WORDS  = `VSLD_WORDS_PER_VREG;
  localparam int OFF_W  = $clog2(WB);
  localparam int WIDX_W = $clog2(WORDS);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    RESPOND
  } sld_state_e;

  sld_state_e       state_q;
  sld_req_t         req_q;
  vlen_t            cnt_q;
  logic             prefetch_q;
  vreg_data_t       ovf_q;
  vreg_data_t       ovf_d;
  logic             accept;
  vlen_t            start_cnt;
  logic             is_up;
  logic [OFF_W-1:0] in_off;
  logic [3:0]       amt_word;
  vlen_t            ew_bytes;
  vlen_t            word_base;
  logic [3:0]       dst_word;
  logic [3:0]       src_word;
  logic             src_valid;
  logic             last_word;
  vreg_data_t       data_in;
  vreg_data_t       data_high;
  vreg_data_t       data_low;
  vreg_data_t       data_out;

  function automatic vreg_data_t byte_rev(input vreg_data_t d);
    vreg_data_t r;
    for (int b = 0; b < WB; b++) begin
      r[8*(WB-1-b) +: 8] = d[8*b +: 8];
    end
    return r;
  endfunction

  ////////////////////
  // Request decode
  ////////////////////

  // New work only after the host has released the last response
  assign req_ready_o = (state_q == IDLE) && !rsp_ack_i;
  assign accept      = req_valid_i && req_ready_o;

  // Plain slide-up skips the untouched low bytes, slide1up writes from element 0
  assign start_cnt = (req_i.cmd.op == VSLIDEUP) ? req_i.amount_bytes : '0;

  assign is_up    = req_q.cmd.op inside {VSLIDEUP, VSLIDE1UP};
  assign in_off   = req_q.amount_bytes[OFF_W-1:0];
  assign amt_word = 4'(req_q.amount_bytes >> OFF_W);
  assign ew_bytes = vlen_t'(1) << req_q.cmd.vsew;

  ////////////////////
  // Address generation
  ////////////////////

  assign word_base = {cnt_q[$bits(vlen_t)-1:OFF_W], {OFF_W{1'b0}}};
  assign dst_word  = 4'(cnt_q >> OFF_W);
  assign last_word = (word_base + vlen_t'(WB)) >= req_q.vl_bytes;

  always_comb begin
    if (is_up) begin
      src_valid = dst_word >= amt_word;
      src_word  = dst_word - amt_word;
    end else begin
      // One word ahead of the prefetched word when the offset is unaligned
      src_word  = dst_word + amt_word + 4'((in_off != '0) && !prefetch_q);
      src_valid = src_word < WORDS;
    end
  end

  assign vrf_raddr_o = {req_q.cmd.vs2, src_word[WIDX_W-1:0]};

  ////////////////////
  // Shifter
  ////////////////////

  always_comb begin
    vlen_t byte_pos;
    logic  ins;
    // Words beyond VLMAX, or before word 0, read as zero
    data_in = src_valid ? vrf_rdata_i : '0;
    if (is_up) begin
      data_in = byte_rev(data_in);
    end
    data_high = data_in >> (8 * in_off);
    data_low  = data_in << (8 * (WB - in_off));

    ovf_d = ovf_q;
    if (is_up) begin
      data_out = byte_rev(data_high | ovf_q);
      if (state_q == RUN) begin
        ovf_d = data_low;
      end
    end else begin
      data_out = (in_off == '0) ? data_high : (data_low | ovf_q);
      if (state_q == RUN) begin
        ovf_d = data_high;
      end
    end
    if (accept) begin
      ovf_d = '0;
    end

    // Byte enables and scalar insertion, byte by byte
    vrf_wreq_o.waddr = {req_q.cmd.vd, dst_word[WIDX_W-1:0]};
    vrf_wreq_o.wdata = data_out;
    for (int j = 0; j < WB; j++) begin
      byte_pos = word_base + vlen_t'(j);
      vrf_wreq_o.wbe[j] = (byte_pos >= cnt_q) && (byte_pos < req_q.vl_bytes);
      ins = ((req_q.cmd.op == VSLIDE1UP) && (byte_pos < ew_bytes)) ||
            ((req_q.cmd.op == VSLIDE1DOWN) && (byte_pos + ew_bytes >= req_q.vl_bytes));
      if (ins) begin
        vrf_wreq_o.wdata[8*j +: 8] = req_q.cmd.rs1[8*j +: 8];
      end
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      prefetch_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            cnt_q      <= start_cnt;
            prefetch_q <= !(req_i.cmd.op inside {VSLIDEUP, VSLIDE1UP}) &&
                          (req_i.amount_bytes[OFF_W-1:0] != '0);
            // Nothing to write when the start is already past vl
            state_q    <= (start_cnt >= req_i.vl_bytes) ? RESPOND : RUN;
          end
        end
        RUN: begin
          if (prefetch_q) begin
            prefetch_q <= 1'b0;
          end else begin
            cnt_q <= word_base + vlen_t'(WB);
            if (last_word) begin
              state_q <= RESPOND;
            end
          end
        end
        RESPOND: begin
          if (rsp_ack_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    ovf_q <= ovf_d;
  end

  assign vrf_we_o  = (state_q == RUN) && !prefetch_q;
  assign rsp_o.id  = req_q.cmd.id;
  assign rsp_req_o = (state_q == RESPOND);

endmodule

// File: vsldu/vsld_vrf.sv
////////////////////
// Vector register file, one word per address
// Byte-enabled slider write, full-word host write, two async reads
////////////////////
`timescale 1ns/1ps
`include "vsld_settings.svh"

module vsld_vrf import vsld_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  vreg_addr_t raddr_i,
  output vreg_data_t rdata_o,
  input  vrf_wreq_t  wreq_i,
  input  logic       we_i,
  input  vreg_addr_t host_addr_i,
  input  vreg_data_t host_wdata_i,
  input  logic       host_we_i,
  output vreg_data_t host_rdata_o
);

  localparam int NR_WORDS = `VSLD_NR_VREGS * `VSLD_WORDS_PER_VREG;
  localparam int WB       = `VSLD_WORD_BYTES;

  vreg_data_t mem_q [NR_WORDS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int w = 0; w < NR_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      // Host only writes while the slider is idle
      if (host_we_i) begin
        mem_q[host_addr_i] <= host_wdata_i;
      end
      if (we_i) begin
        for (int b = 0; b < WB; b++) begin
          if (wreq_i.wbe[b]) begin
            mem_q[wreq_i.waddr][8*b +: 8] <= wreq_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Slider read port
  assign rdata_o = mem_q[raddr_i];

  // Host read port
  assign host_rdata_o = mem_q[host_addr_i];

endmodule
